// File: rtl/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int num_sets       = 8;
    localparam int num_ways       = 8;
    localparam int words_per_line = 16;
    localparam int offset_bits    = 6;
    localparam int index_bits     = 3;
    localparam int tag_bits       = 23;
    localparam int word_bits      = 32;

    // address and data
    typedef logic [31:0]          addr_t;
    typedef logic [word_bits-1:0] word_t;
    typedef logic [tag_bits-1:0]  tag_t;

    // array selectors
    typedef logic [index_bits-1:0]                 set_idx_t;
    typedef logic [$clog2(num_ways)-1:0]           way_t;
    typedef logic [$clog2(words_per_line)-1:0]     word_idx_t;

    // one MRU bit per way of a set
    typedef logic [num_ways-1:0] mru_t;

    // request kind
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_e;

    // controller sequencing
    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_lookup     = 3'd1,
        st_resolve    = 3'd2,
        st_write_back = 3'd3,
        st_refill     = 3'd4,
        st_finish     = 3'd5
    } ctrl_state_e;

endpackage

// File: rtl/plru_way_select.sv
`timescale 1ns/1ps

module plru_way_select (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::way_t   hit_way,
    input  logic              access_hit,
    input  logic              access_miss,
    output cache_pkg::way_t   victim_way
);
    import cache_pkg::*;

    mru_t mru_q [num_sets];
    mru_t cur_mru;
    way_t free_way;

    assign cur_mru = mru_q[set_idx];

    // highest way whose MRU bit is still clear
    always_comb begin
        free_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (!cur_mru[i]) begin
                free_way = way_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                mru_q[s] <= '0;
            end
            victim_way <= '0;
        end else if (access_hit) begin
            mru_q[set_idx][hit_way] <= 1'b1;
            victim_way <= hit_way;
        end else if (access_miss) begin
            if (&cur_mru) begin
                // all ways recently used, restart with way 7 only
                mru_q[set_idx] <= mru_t'(1) << (num_ways - 1);
                victim_way <= way_t'(num_ways - 1);
            end else begin
                mru_q[set_idx] <= cur_mru | (mru_t'(1) << free_way);
                victim_way <= free_way;
            end
        end
    end

    // controller issues exactly one strobe per lookup
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(access_hit && access_miss));

endmodule

// File: rtl/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::way_t     victim_way,
    input  logic                wr_en,
    input  cache_pkg::way_t     wr_way,
    input  logic                wr_dirty,
    output logic                hit,
    output cache_pkg::way_t     hit_way,
    output logic                victim_valid,
    output logic                victim_dirty,
    output cache_pkg::tag_t     victim_tag
);
    import cache_pkg::*;

    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    tag_t                tag_q   [num_sets][num_ways];
    logic [num_ways-1:0] match;

    // eight-way compare on the selected set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit          = |match;
    assign victim_valid = valid_q[set_idx][victim_way];
    assign victim_dirty = dirty_q[set_idx][victim_way];
    assign victim_tag   = tag_q[set_idx][victim_way];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en) begin
            valid_q[set_idx][wr_way] <= 1'b1;
        end
    end

    // tag and dirty only count under a valid bit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[set_idx][wr_way]   <= tag;
            dirty_q[set_idx][wr_way] <= wr_dirty;
        end
    end

    // a line is never allocated twice in one set
    a_single_match: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(match));

endmodule

// File: rtl/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic                 clk,
    input  cache_pkg::set_idx_t  set_idx,
    input  cache_pkg::way_t      way,
    input  cache_pkg::word_idx_t word_idx,
    input  logic                 wr_en,
    input  cache_pkg::word_t     wr_word,
    output cache_pkg::word_t     rd_word
);
    import cache_pkg::*;

    // sets x ways x words of line data
    word_t data_q [num_sets][num_ways][words_per_line];

    // one word per enabled edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[set_idx][way][word_idx] <= wr_word;
        end
    end

    // combinational read, used for hits and write-back streaming
    assign rd_word = data_q[set_idx][way][word_idx];

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::addr_t     addr,
    input  logic                 rd,
    input  logic                 wr,
    input  cache_pkg::word_t     in_data,
    input  logic                 hit,
    input  cache_pkg::way_t      hit_way,
    input  cache_pkg::way_t      victim_way,
    input  logic                 victim_valid,
    input  logic                 victim_dirty,
    input  cache_pkg::tag_t      victim_tag,
    input  cache_pkg::word_t     rd_word,
    input  cache_pkg::word_t     rd_from_mem,
    input  logic                 mem_op_finish,
    output cache_pkg::word_t     out_data,
    output logic                 data_rdy,
    output cache_pkg::set_idx_t  set_idx,
    output cache_pkg::tag_t      tag,
    output logic                 access_hit,
    output logic                 access_miss,
    output logic                 tag_wr_en,
    output cache_pkg::way_t      tag_wr_way,
    output logic                 tag_wr_dirty,
    output cache_pkg::way_t      data_way,
    output cache_pkg::word_idx_t data_word_idx,
    output logic                 data_wr_en,
    output cache_pkg::word_t     data_wr_word,
    output cache_pkg::addr_t     mem_addr,
    output cache_pkg::word_t     wr_to_mem,
    output logic                 r_w,
    output logic                 enable
);
    import cache_pkg::*;

    ctrl_state_e state;
    cache_op_e   op;
    word_idx_t   burst_cnt;
    addr_t       req_addr;
    word_t       req_data;

    set_idx_t  req_set;
    tag_t      req_tag;
    word_idx_t req_word;
    addr_t     line_base;
    logic      word_done;
    logic      last_word;
    logic      hit_write;
    logic      victim_wb;

    // fields of the captured request
    assign req_set   = req_addr[offset_bits +: index_bits];
    assign req_tag   = req_addr[offset_bits + index_bits +: tag_bits];
    assign req_word  = req_addr[offset_bits-1:2];
    assign line_base = {req_addr[31:offset_bits], {offset_bits{1'b0}}};

    assign word_done = enable && mem_op_finish;
    assign last_word = burst_cnt == word_idx_t'(words_per_line - 1);
    assign hit_write = (state == st_resolve) && hit && (op == op_write);
    assign victim_wb = victim_valid && victim_dirty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            op        <= op_read;
            burst_cnt <= '0;
            enable    <= 1'b0;
            r_w       <= 1'b0;
            data_rdy  <= 1'b0;
        end else begin
            data_rdy <= 1'b0;
            case (state)
                st_idle: begin
                    if (rd || wr) begin
                        op    <= wr ? op_write : op_read;
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    state <= st_resolve;
                end
                st_resolve: begin
                    if (hit) begin
                        data_rdy <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        burst_cnt <= '0;
                        enable    <= 1'b1;
                        r_w       <= victim_wb;
                        state     <= victim_wb ? st_write_back : st_refill;
                    end
                end
                st_write_back: begin
                    if (word_done) begin
                        burst_cnt <= burst_cnt + word_idx_t'(1);
                        if (last_word) begin
                            // drop enable for a cycle between bursts
                            enable <= 1'b0;
                            r_w    <= 1'b0;
                            state  <= st_refill;
                        end
                    end
                end
                st_refill: begin
                    if (!enable) begin
                        enable <= 1'b1;
                    end else if (mem_op_finish) begin
                        burst_cnt <= burst_cnt + word_idx_t'(1);
                        if (last_word) begin
                            enable <= 1'b0;
                            state  <= st_finish;
                        end
                    end
                end
                st_finish: begin
                    data_rdy <= 1'b1;
                    state    <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && (rd || wr)) begin
            req_addr <= addr;
            req_data <= in_data;
        end
        if (op == op_read && ((state == st_resolve && hit) || state == st_finish)) begin
            out_data <= rd_word;
        end
        // victim line base first, then the requested line
        if (state == st_resolve && !hit) begin
            mem_addr <= victim_wb ? {victim_tag, req_set, {offset_bits{1'b0}}} : line_base;
        end else if (state == st_write_back && word_done && last_word) begin
            mem_addr <= line_base;
        end else if (word_done) begin
            mem_addr <= mem_addr + 32'd4;
        end
    end

    assign set_idx     = req_set;
    assign tag         = req_tag;
    assign access_hit  = (state == st_lookup) && hit;
    assign access_miss = (state == st_lookup) && !hit;

    // hits address the matching way, misses the chosen victim
    assign data_way     = (state == st_resolve) ? hit_way : victim_way;
    assign tag_wr_way   = data_way;
    assign tag_wr_en    = hit_write || (state == st_finish);
    assign tag_wr_dirty = op == op_write;

    assign data_word_idx = (state == st_write_back || state == st_refill) ? burst_cnt : req_word;
    assign data_wr_en    = hit_write || (state == st_refill && word_done) ||
                           (state == st_finish && op == op_write);
    assign data_wr_word  = (state == st_refill) ? rd_from_mem : req_data;

    // victim words stream straight out of the data array
    assign wr_to_mem = rd_word;

    a_no_enable_at_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy |-> !enable);

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (enable && !mem_op_finish) |=> $stable(mem_addr));

endmodule

// File: rtl/set_assoc_cache.sv
`timescale 1ns/1ps

module set_assoc_cache (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::addr_t addr,
    input  logic             rd,
    input  logic             wr,
    input  cache_pkg::word_t in_data,
    output cache_pkg::word_t out_data,
    output logic             data_rdy,
    input  cache_pkg::word_t rd_from_mem,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t wr_to_mem,
    output logic             r_w,
    output logic             enable,
    input  logic             mem_op_finish
);
    import cache_pkg::*;

    set_idx_t  set_idx;
    tag_t      tag;
    logic      access_hit;
    logic      access_miss;
    logic      tag_wr_en;
    way_t      tag_wr_way;
    logic      tag_wr_dirty;
    way_t      data_way;
    word_idx_t data_word_idx;
    logic      data_wr_en;
    word_t     data_wr_word;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_valid;
    logic      victim_dirty;
    tag_t      victim_tag;
    word_t     rd_word;

    cache_ctrl i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr          (addr),
        .rd            (rd),
        .wr            (wr),
        .in_data       (in_data),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_valid  (victim_valid),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .rd_word       (rd_word),
        .rd_from_mem   (rd_from_mem),
        .mem_op_finish (mem_op_finish),
        .out_data      (out_data),
        .data_rdy      (data_rdy),
        .set_idx       (set_idx),
        .tag           (tag),
        .access_hit    (access_hit),
        .access_miss   (access_miss),
        .tag_wr_en     (tag_wr_en),
        .tag_wr_way    (tag_wr_way),
        .tag_wr_dirty  (tag_wr_dirty),
        .data_way      (data_way),
        .data_word_idx (data_word_idx),
        .data_wr_en    (data_wr_en),
        .data_wr_word  (data_wr_word),
        .mem_addr      (mem_addr),
        .wr_to_mem     (wr_to_mem),
        .r_w           (r_w),
        .enable        (enable)
    );

    tag_lookup i_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_idx      (set_idx),
        .tag          (tag),
        .victim_way   (victim_way),
        .wr_en        (tag_wr_en),
        .wr_way       (tag_wr_way),
        .wr_dirty     (tag_wr_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    plru_way_select i_plru (
        .clk         (clk),
        .rst_n       (rst_n),
        .set_idx     (set_idx),
        .hit_way     (hit_way),
        .access_hit  (access_hit),
        .access_miss (access_miss),
        .victim_way  (victim_way)
    );

    line_store i_data (
        .clk      (clk),
        .set_idx  (set_idx),
        .way      (data_way),
        .word_idx (data_word_idx),
        .wr_en    (data_wr_en),
        .wr_word  (data_wr_word),
        .rd_word  (rd_word)
    );

endmodule

// File: tb/cache_tests.svh
`ifndef cache_tests_svh
`define cache_tests_svh

// each row holds op, address, write data, expected read data,
// expected write transfers since reset, expected write-back base
// (zero when no line goes back) and expected hit

typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    word_t     wr_data;
    word_t     exp_data;
    int        exp_writes;
    addr_t     exp_wb_base;
    logic      exp_hit;
} test_row_t;

localparam int num_tests = 21;

localparam test_row_t tests [num_tests] = '{
    // cold read miss into way 7 of set 1
    '{op_read,  32'h0000_1044, 32'h0000_0000, 32'h5a5a_1044, 0,  32'h0000_0000, 1'b0},
    // write miss into set 2 and a read hit on the same word
    '{op_write, 32'h0002_0088, 32'h1111_0000, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_read,  32'h0002_0088, 32'h0000_0000, 32'h1111_0000, 0,  32'h0000_0000, 1'b1},
    // seven more tags fill ways 6 down to 0 of set 2
    '{op_write, 32'h0002_0288, 32'h1111_0001, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0488, 32'h1111_0002, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0688, 32'h1111_0003, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0888, 32'h1111_0004, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0a88, 32'h1111_0005, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0c88, 32'h1111_0006, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    '{op_write, 32'h0002_0e88, 32'h1111_0007, 32'h0000_0000, 0,  32'h0000_0000, 1'b0},
    // ninth tag wraps to way 7 and writes back the first line
    '{op_read,  32'h0002_1088, 32'h0000_0000, 32'h5a58_1088, 16, 32'h0002_0080, 1'b0},
    // first line comes back from memory while way 6 is written back
    '{op_read,  32'h0002_0088, 32'h0000_0000, 32'h1111_0000, 32, 32'h0002_0280, 1'b0},
    // read-only lines in set 1 cost no write transfer on eviction
    '{op_read,  32'h0000_1244, 32'h0000_0000, 32'h5a5a_1244, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1444, 32'h0000_0000, 32'h5a5a_1444, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1644, 32'h0000_0000, 32'h5a5a_1644, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1844, 32'h0000_0000, 32'h5a5a_1844, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1a44, 32'h0000_0000, 32'h5a5a_1a44, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1c44, 32'h0000_0000, 32'h5a5a_1c44, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_1e44, 32'h0000_0000, 32'h5a5a_1e44, 32, 32'h0000_0000, 1'b0},
    '{op_read,  32'h0000_2044, 32'h0000_0000, 32'h5a5a_2044, 32, 32'h0000_0000, 1'b0},
    // the evicted clean line misses again
    '{op_read,  32'h0000_1044, 32'h0000_0000, 32'h5a5a_1044, 32, 32'h0000_0000, 1'b0}
};

`endif

// File: tb/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    `include "cache_tests.svh"

    localparam int max_cycles = num_tests * 200;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    logic  rd;
    logic  wr;
    word_t in_data;
    word_t out_data;
    logic  data_rdy;
    word_t rd_from_mem;
    addr_t mem_addr;
    word_t wr_to_mem;
    logic  r_w;
    logic  enable;
    logic  mem_op_finish;

    // memory model state
    word_t mem_words [addr_t];
    int    mem_delay;
    int    wr_count;
    addr_t rd_addrs [$];
    addr_t wr_addrs [$];
    int    cycles;

    set_assoc_cache i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr          (addr),
        .rd            (rd),
        .wr            (wr),
        .in_data       (in_data),
        .out_data      (out_data),
        .data_rdy      (data_rdy),
        .rd_from_mem   (rd_from_mem),
        .mem_addr      (mem_addr),
        .wr_to_mem     (wr_to_mem),
        .r_w           (r_w),
        .enable        (enable),
        .mem_op_finish (mem_op_finish)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // unwritten words read back as a pattern of their own address
    function automatic word_t mem_read(addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %08h, expected %08h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong data word");
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %08h, expected %08h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong address");
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong count");
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong control bit");
        end
    endtask

    // each word answered 1 to 4 cycles after it is requested
    initial begin
        void'($urandom(32'hf78f));
        mem_op_finish = 1'b0;
        rd_from_mem   = '0;
        mem_delay     = 0;
        wr_count      = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_op_finish = 1'b0;
            if (!enable) begin
                mem_delay = 0;
            end else begin
                if (mem_delay == 0) begin
                    mem_delay = int'($urandom_range(4, 1));
                end
                mem_delay = mem_delay - 1;
                if (mem_delay == 0) begin
                    if (r_w) begin
                        mem_words[mem_addr] = wr_to_mem;
                        wr_addrs.push_back(mem_addr);
                        wr_count++;
                    end else begin
                        rd_from_mem = mem_read(mem_addr);
                        rd_addrs.push_back(mem_addr);
                    end
                    mem_op_finish = 1'b1;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout: the cache gave no answer within %0d cycles", max_cycles);
                $display("RESULT: FAIL");
                $fatal(1, "simulation timed out");
            end
        end
    end

    initial begin
        test_row_t row;
        int        edges;
        addr_t     base;

        rst_n      = 1'b0;
        rd         = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        in_data    = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("data_rdy", data_rdy, 1'b0);
        check_bit("enable", enable, 1'b0);
        check_bit("r_w", r_w, 1'b0);

        for (int i = 0; i < num_tests; i++) begin
            row = tests[i];
            rd_addrs.delete();
            wr_addrs.delete();
            @(posedge clk);
            #1;
            addr    = row.addr;
            in_data = row.wr_data;
            rd      = (row.op == op_read);
            wr      = (row.op == op_write);
            // strobe lasts one cycle before the wait for completion
            edges = 0;
            while (!data_rdy) begin
                @(posedge clk);
                #1;
                edges++;
                rd = 1'b0;
                wr = 1'b0;
            end

            if (row.op == op_read) begin
                check_word("out_data", out_data, row.exp_data);
            end
            check_count("write transfers", wr_count, row.exp_writes);
            if (row.exp_hit) begin
                check_count("hit latency in edges", edges, 3);
                check_count("read transfers on hit", rd_addrs.size(), 0);
                check_count("write transfers on hit", wr_addrs.size(), 0);
            end else begin
                // refill covers the requested line in ascending order
                check_count("refill words", rd_addrs.size(), 16);
                base = {row.addr[31:6], 6'b000000};
                foreach (rd_addrs[k]) begin
                    check_addr("refill mem_addr", rd_addrs[k], base + addr_t'(4 * k));
                end
                if (row.exp_wb_base != '0) begin
                    check_count("write-back words", wr_addrs.size(), 16);
                    foreach (wr_addrs[k]) begin
                        check_addr("write-back mem_addr", wr_addrs[k],
                                   row.exp_wb_base + addr_t'(4 * k));
                    end
                end else begin
                    check_count("write-back words", wr_addrs.size(), 0);
                end
            end
        end

        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+tb
rtl/cache_pkg.sv
rtl/plru_way_select.sv
rtl/tag_lookup.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/set_assoc_cache.sv
tb/tb_cache.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f all.f --top-module tb_cache -o tb_cache_sim &&
out=$(./obj_dir/tb_cache_sim; true) &&
echo "$out" &&
echo "$out" | grep -q "^RESULT: PASS$" ||
{ echo "simulation did not pass"; exit 1; }
